/* design/soc_bus_pkg.sv */
`default_nettype none

// valid/ready bus shared by the master port and every target
package soc_bus_pkg;

	// one request; the master holds it stable until ready
	typedef struct packed {
		logic        valid;
		// byte address
		logic [31:0] addr;
		logic [31:0] wdata;
		// byte lanes to write, all zero for a read
		logic [3:0]  wstrb;
	} bus_req_t;

	// one response from the addressed target
	typedef struct packed {
		// completes the transfer in this cycle
		logic        ready;
		logic [31:0] rdata;
	} bus_rsp_t;

endpackage

`default_nettype wire

/* design/soc_map_pkg.sv */
`default_nettype none

// address map of the subsystem
package soc_map_pkg;

	// decoded target of a request
	typedef enum logic [2:0] {
		tgt_ram,
		tgt_uart_div,
		tgt_uart_dat,
		tgt_io,
		tgt_none
	} target_e;

	// uart register addresses, matched exactly
	parameter logic [31:0] UART_DIV_ADDR = 32'h0200_0004;
	parameter logic [31:0] UART_DAT_ADDR = 32'h0200_0008;

	// addr[31:24] from this value up goes to external io
	parameter logic [7:0] IO_MIN_TOP_BYTE = 8'h02;

	// bit period in clock cycles after reset
	parameter logic [31:0] UART_DIV_RESET = 32'd16;

endpackage

`default_nettype wire

/* design/soc_bus_decode.sv */
`timescale 1ns/100ps
`default_nettype none

// address decoder and response mux between the master port and the targets
module soc_bus_decode #(
	parameter integer mem_words = 256
) (
	input  wire soc_bus_pkg::bus_req_t host_req,
	output soc_bus_pkg::bus_rsp_t      host_rsp,

	output soc_bus_pkg::bus_req_t      ram_req,
	input  wire soc_bus_pkg::bus_rsp_t ram_rsp,

	output soc_bus_pkg::bus_req_t      div_req,
	input  wire soc_bus_pkg::bus_rsp_t div_rsp,

	output soc_bus_pkg::bus_req_t      dat_req,
	input  wire soc_bus_pkg::bus_rsp_t dat_rsp,

	output soc_bus_pkg::bus_req_t      io_req,
	input  wire soc_bus_pkg::bus_rsp_t io_rsp
);

	// first byte address past the sram
	localparam logic [31:0] ram_limit = 32'(4 * mem_words);

	soc_map_pkg::target_e tgt;

	logic in_ram;
	logic is_div;
	logic is_dat;
	logic in_io;

	assign in_ram = host_req.addr < ram_limit;
	assign is_div = host_req.addr == soc_map_pkg::UART_DIV_ADDR;
	assign is_dat = host_req.addr == soc_map_pkg::UART_DAT_ADDR;
	assign in_io  = host_req.addr[31:24] >= soc_map_pkg::IO_MIN_TOP_BYTE;

	// priority order: ram, uart registers, external io, nothing
	always_comb begin
		if (in_ram) begin
			tgt = soc_map_pkg::tgt_ram;
		end else if (is_div) begin
			tgt = soc_map_pkg::tgt_uart_div;
		end else if (is_dat) begin
			tgt = soc_map_pkg::tgt_uart_dat;
		end else if (in_io) begin
			tgt = soc_map_pkg::tgt_io;
		end else begin
			tgt = soc_map_pkg::tgt_none;
		end
	end

	// every target sees the request, only the selected one sees valid
	always_comb begin
		ram_req = host_req;
		div_req = host_req;
		dat_req = host_req;
		io_req  = host_req;

		ram_req.valid = host_req.valid && (tgt == soc_map_pkg::tgt_ram);
		div_req.valid = host_req.valid && (tgt == soc_map_pkg::tgt_uart_div);
		dat_req.valid = host_req.valid && (tgt == soc_map_pkg::tgt_uart_dat);
		io_req.valid  = host_req.valid && (tgt == soc_map_pkg::tgt_io);
	end

	// response of the selected target, idle bus answers with zero
	always_comb begin
		host_rsp = '0;
		if (host_req.valid) begin
			case (tgt)
				soc_map_pkg::tgt_ram: begin
					host_rsp = ram_rsp;
				end
				soc_map_pkg::tgt_uart_div: begin
					host_rsp = div_rsp;
				end
				soc_map_pkg::tgt_uart_dat: begin
					host_rsp = dat_rsp;
				end
				soc_map_pkg::tgt_io: begin
					host_rsp = io_rsp;
				end
				default: begin
					// unmapped: complete at once with zero data so the bus cannot hang
					host_rsp.ready = 1'b1;
					host_rsp.rdata = '0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/soc_sram.sv */
`timescale 1ns/100ps
`default_nettype none

// on-chip sram, 32-bit words with byte write strobes and one wait state
module soc_sram #(
	parameter integer mem_words = 256
) (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire soc_bus_pkg::bus_req_t req,
	output soc_bus_pkg::bus_rsp_t      rsp
);

	localparam integer addr_bits = (mem_words > 1) ? $clog2(mem_words) : 1;

	logic [31:0] mem [mem_words];
	logic [31:0] rdata_q;
	logic        ready_q;
	logic [addr_bits-1:0] word_idx;

	// word index from the byte address
	assign word_idx = req.addr[2 +: addr_bits];

	// ready is high for one cycle, then low again before the next access
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ready_q <= 1'b0;
		end else begin
			ready_q <= req.valid && !ready_q;
		end
	end

	// read on the first edge, write lanes on the edge that samples ready
	always_ff @(posedge clk) begin
		if (req.valid && !ready_q) begin
			rdata_q <= mem[word_idx];
		end
		if (req.valid && ready_q) begin
			for (int i = 0; i < 4; i++) begin
				if (req.wstrb[i]) begin
					mem[word_idx][8*i +: 8] <= req.wdata[8*i +: 8];
				end
			end
		end
	end

	assign rsp.ready = ready_q;
	assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

/* design/soc_uart.sv */
`timescale 1ns/100ps
`default_nettype none

// 8N1 uart with a divider register and a one-byte data register
module soc_uart (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire soc_bus_pkg::bus_req_t div_req,
	output soc_bus_pkg::bus_rsp_t      div_rsp,
	input  wire soc_bus_pkg::bus_req_t dat_req,
	output soc_bus_pkg::bus_rsp_t      dat_rsp,
	output logic                       ser_tx,
	input  wire                        ser_rx
);

	logic [31:0] div_q;

	logic        dat_wr;
	logic        dat_rd;
	logic        tx_busy;
	logic        tx_start;
	logic        tx_tick;
	logic [3:0]  tx_bits;
	logic [31:0] tx_cnt;
	logic [8:0]  tx_shift;

	logic [1:0]  rx_sync;
	logic        rx_in;
	logic        rx_busy;
	logic        rx_sample;
	logic        rx_done;
	logic [3:0]  rx_bits;
	logic [31:0] rx_cnt;
	logic [7:0]  rx_shift;
	logic [7:0]  rx_buf;
	logic        rx_valid;

	// divider register, byte writable
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_q <= soc_map_pkg::UART_DIV_RESET;
		end else if (div_req.valid) begin
			for (int i = 0; i < 4; i++) begin
				if (div_req.wstrb[i]) begin
					div_q[8*i +: 8] <= div_req.wdata[8*i +: 8];
				end
			end
		end
	end

	assign div_rsp.ready = div_req.valid;
	assign div_rsp.rdata = div_q;

	assign dat_wr   = dat_req.valid && (dat_req.wstrb != 4'b0000);
	assign dat_rd   = dat_req.valid && (dat_req.wstrb == 4'b0000);
	assign tx_busy  = tx_bits != 4'd0;
	assign tx_start = dat_wr && !tx_busy;

	// a write stalls while the previous byte is still on the line
	assign dat_rsp.ready = dat_req.valid && !(dat_wr && tx_busy);
	assign dat_rsp.rdata = rx_valid ? {24'h000000, rx_buf} : 32'hffff_ffff;

	// end of the current bit period, divider 0 or 1 ticks every cycle
	assign tx_tick = (tx_cnt + 32'd1) >= div_q;

	// transmitter, start bit driven directly, then shift out data and stop
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ser_tx  <= 1'b1;
			tx_bits <= 4'd0;
			tx_cnt  <= '0;
		end else if (tx_start) begin
			ser_tx  <= 1'b0;
			tx_bits <= 4'd10;
			tx_cnt  <= '0;
		end else if (tx_busy) begin
			if (tx_tick) begin
				tx_cnt  <= '0;
				tx_bits <= tx_bits - 4'd1;
				ser_tx  <= tx_shift[0];
			end else begin
				tx_cnt <= tx_cnt + 32'd1;
			end
		end
	end

	// ones fill in behind the data, which gives the stop bit and idle
	always_ff @(posedge clk) begin
		if (tx_start) begin
			tx_shift <= {1'b1, dat_req.wdata[7:0]};
		end else if (tx_busy && tx_tick) begin
			tx_shift <= {1'b1, tx_shift[8:1]};
		end
	end

	// two-flop synchronizer on the serial input
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync <= 2'b11;
		end else begin
			rx_sync <= {rx_sync[0], ser_rx};
		end
	end

	assign rx_in     = rx_sync[1];
	assign rx_busy   = rx_bits != 4'd0;
	assign rx_sample = rx_busy && (rx_cnt == 32'd0);
	assign rx_done   = rx_sample && (rx_bits == 4'd1) && rx_in;

	// receiver counts down half a bit to the middle of the start bit, then whole bits
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_bits <= 4'd0;
			rx_cnt  <= '0;
		end else if (!rx_busy) begin
			if (!rx_in) begin
				rx_bits <= 4'd10;
				// synchronizer and start detect already take up part of the half bit
				rx_cnt  <= (div_q > 32'd3) ? {1'b0, div_q[31:1]} - 32'd1 : '0;
			end
		end else if (rx_sample) begin
			rx_cnt <= div_q - 32'd1;
			// a start bit that is gone by mid-bit was a glitch
			if (rx_bits == 4'd10 && rx_in) begin
				rx_bits <= 4'd0;
			end else begin
				rx_bits <= rx_bits - 4'd1;
			end
		end else begin
			rx_cnt <= rx_cnt - 32'd1;
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge clk) begin
		if (rx_sample && rx_bits <= 4'd9 && rx_bits >= 4'd2) begin
			rx_shift <= {rx_in, rx_shift[7:1]};
		end
		if (rx_done) begin
			rx_buf <= rx_shift;
		end
	end

	// a new byte wins over a read in the same cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_valid <= 1'b0;
		end else if (rx_done) begin
			rx_valid <= 1'b1;
		end else if (dat_rd) begin
			rx_valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* design/soc_top.sv */
`timescale 1ns/100ps
`default_nettype none

// peripheral subsystem: bus decode, sram and uart behind one master port
module soc_top #(
	parameter integer mem_words = 256
) (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire soc_bus_pkg::bus_req_t host_req,
	output wire soc_bus_pkg::bus_rsp_t host_rsp,
	output wire soc_bus_pkg::bus_req_t io_req,
	input  wire soc_bus_pkg::bus_rsp_t io_rsp,
	output wire                        ser_tx,
	input  wire                        ser_rx
);

	soc_bus_pkg::bus_req_t ram_req;
	soc_bus_pkg::bus_rsp_t ram_rsp;
	soc_bus_pkg::bus_req_t div_req;
	soc_bus_pkg::bus_rsp_t div_rsp;
	soc_bus_pkg::bus_req_t dat_req;
	soc_bus_pkg::bus_rsp_t dat_rsp;

	soc_bus_decode #(
		.mem_words(mem_words)
	) i_decode (
		.host_req(host_req),
		.host_rsp(host_rsp),
		.ram_req (ram_req),
		.ram_rsp (ram_rsp),
		.div_req (div_req),
		.div_rsp (div_rsp),
		.dat_req (dat_req),
		.dat_rsp (dat_rsp),
		.io_req  (io_req),
		.io_rsp  (io_rsp)
	);

	soc_sram #(
		.mem_words(mem_words)
	) i_sram (
		.clk  (clk),
		.rst_n(rst_n),
		.req  (ram_req),
		.rsp  (ram_rsp)
	);

	// both uart registers live in one block
	soc_uart i_uart (
		.clk    (clk),
		.rst_n  (rst_n),
		.div_req(div_req),
		.div_rsp(div_rsp),
		.dat_req(dat_req),
		.dat_rsp(dat_rsp),
		.ser_tx (ser_tx),
		.ser_rx (ser_rx)
	);

endmodule

`default_nettype wire

/* tests/tb_soc_model.svh */
`ifndef TB_SOC_MODEL_SVH
`define TB_SOC_MODEL_SVH

// expected sram contents and divider register
logic [31:0] ram_shadow [mem_words];
logic [31:0] div_model;

// new bytes where the strobe is set, old bytes elsewhere
function automatic logic [31:0] merge_bytes(
	input logic [31:0] old_data,
	input logic [31:0] wdata,
	input logic [3:0]  strb
);
	logic [31:0] v;
	v = old_data;
	for (int i = 0; i < 4; i++) begin
		if (strb[i]) begin
			v[8*i +: 8] = wdata[8*i +: 8];
		end
	end
	return v;
endfunction

// one transfer; called just after a rising edge, returns just after the completing edge
task automatic bus_xfer(
	input  logic [31:0] addr,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	output logic [31:0] rdata,
	output integer      cycles
);
	logic done;
	done           = 1'b0;
	cycles         = 0;
	rdata          = '0;
	host_req.valid = 1'b1;
	host_req.addr  = addr;
	host_req.wdata = wdata;
	host_req.wstrb = wstrb;
	while (!done) begin
		@(negedge clk);
		cycles = cycles + 1;
		if (host_rsp.ready) begin
			rdata = host_rsp.rdata;
			done  = 1'b1;
		end
		@(posedge clk);
		#drive_dly;
	end
	host_req = '0;
endtask

// sram accesses span exactly two cycles, valid cycle and ready cycle
task automatic ram_write(input integer idx, input logic [31:0] wdata, input logic [3:0] strb);
	logic [31:0] rdata;
	integer      cycles;
	bus_xfer(32'(4 * idx), wdata, strb, rdata, cycles);
	assert (cycles == 2)
		else value_error($sformatf("sram write to word %0d took %0d cycles", idx, cycles));
	ram_shadow[idx] = merge_bytes(ram_shadow[idx], wdata, strb);
endtask

task automatic ram_check(input integer idx);
	logic [31:0] rdata;
	integer      cycles;
	bus_xfer(32'(4 * idx), 32'h0, 4'h0, rdata, cycles);
	assert (cycles == 2)
		else value_error($sformatf("sram read of word %0d took %0d cycles", idx, cycles));
	assert (rdata === ram_shadow[idx])
		else value_error($sformatf("sram word %0d read %h, expected %h",
			idx, rdata, ram_shadow[idx]));
endtask

`endif

/* tests/tb_soc.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_soc;

	localparam integer mem_words    = 256;
	localparam integer drive_dly    = 2;
	localparam integer io_dly       = 4;
	localparam integer ram_writes   = 200;
	localparam integer ram_reads    = 200;
	localparam integer io_xfers     = 40;
	localparam integer max_io_delay = 5;
	localparam integer div_rounds   = 16;
	localparam integer unmapped_n   = 12;
	localparam integer uart_bytes   = 8;
	localparam integer uart_div     = 4;
	// fill, random sram traffic, io, divider, unmapped with rereads, and some slack
	localparam integer n_xfers = 2 * mem_words + ram_writes + ram_reads + io_xfers
		+ 2 * div_rounds + 3 * unmapped_n + 100;
	localparam integer timeout_cycles = n_xfers * max_io_delay
		+ uart_bytes * 10 * uart_div + 2000;

	logic clk = 1'b0;
	logic rst_n;
	logic ser_tx;
	soc_bus_pkg::bus_req_t host_req;
	soc_bus_pkg::bus_rsp_t host_rsp;
	soc_bus_pkg::bus_req_t io_req;
	soc_bus_pkg::bus_rsp_t io_rsp;

	logic [15:0] lfsr_q;
	integer      cycle_cnt = 0;

	// what the external device should see and answer
	logic                  io_expect;
	soc_bus_pkg::bus_req_t io_exp_req;
	logic [31:0]           io_exp_rdata;
	integer                io_delay;

	// serial loopback
	soc_top #(
		.mem_words(mem_words)
	) i_dut (
		.clk     (clk),
		.rst_n   (rst_n),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.io_req  (io_req),
		.io_rsp  (io_rsp),
		.ser_tx  (ser_tx),
		.ser_rx  (ser_tx)
	);

	always #20 clk = ~clk;

	// 16-bit fibonacci lfsr, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(input integer n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	task automatic stop_run;
		$display("TB FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic value_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		stop_run();
	endtask

	`include "tb_soc_model.svh"

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("the tests did not finish within %0d clock cycles", timeout_cycles);
			stop_run();
		end
	end

	// io valid never for sram, and only while an external io access is expected
	always @(negedge clk) begin
		if (rst_n) begin
			assert (!io_req.valid || io_req.addr >= 32'(4 * mem_words))
				else value_error($sformatf("sram address %h reached io_req", io_req.addr));
			assert (!io_req.valid || io_expect)
				else value_error($sformatf("io_req valid for address %h", io_req.addr));
		end
	end

	// external device reacts after the host has driven its request
	initial begin : io_device
		integer wait_left;
		logic   active;
		io_rsp    = '0;
		wait_left = 0;
		active    = 1'b0;
		forever begin
			@(posedge clk);
			#io_dly;
			// a ready from the last cycle completed at this edge
			io_rsp = '0;
			if (io_req.valid && !active) begin
				active    = 1'b1;
				wait_left = io_delay;
				assert (io_req.addr === io_exp_req.addr && io_req.wdata === io_exp_req.wdata
					&& io_req.wstrb === io_exp_req.wstrb)
					else value_error($sformatf("io_req shows %h %h %h, expected %h %h %h",
						io_req.addr, io_req.wdata, io_req.wstrb,
						io_exp_req.addr, io_exp_req.wdata, io_exp_req.wstrb));
			end
			if (active) begin
				if (wait_left == 0) begin
					io_rsp.ready = 1'b1;
					io_rsp.rdata = io_exp_rdata;
					active       = 1'b0;
				end else begin
					wait_left = wait_left - 1;
				end
			end
		end
	end

	// pattern that depends on every address bit
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
	endfunction

	task automatic sram_traffic;
		integer     idx;
		logic [3:0] strb;
		for (int i = 0; i < mem_words; i++) begin
			ram_write(i, fill_word(32'(4 * i)), 4'hf);
		end
		for (int n = 0; n < ram_writes; n++) begin
			idx  = int'(rand_bits(16)) % mem_words;
			strb = 4'(rand_bits(4));
			while (strb == 4'h0) begin
				strb = 4'(rand_bits(4));
			end
			ram_write(idx, rand_bits(32), strb);
		end
		for (int n = 0; n < ram_reads; n++) begin
			ram_check(int'(rand_bits(16)) % mem_words);
		end
	endtask

	task automatic io_traffic;
		logic [31:0] addr;
		logic [31:0] rdata;
		integer      cycles;
		for (int n = 0; n < io_xfers; n++) begin
			addr = rand_bits(32);
			while (addr[31:24] < 8'h02 || addr == soc_map_pkg::UART_DIV_ADDR
				|| addr == soc_map_pkg::UART_DAT_ADDR) begin
				addr = rand_bits(32);
			end
			// edges of the io range around the uart registers
			if (n == 0) begin
				addr = 32'h0200_0000;
			end else if (n == 1) begin
				addr = 32'h0200_000c;
			end
			io_exp_req.valid = 1'b1;
			io_exp_req.addr  = addr;
			io_exp_req.wdata = rand_bits(32);
			io_exp_req.wstrb = 4'(rand_bits(4));
			io_exp_rdata     = rand_bits(32);
			io_delay         = int'(rand_bits(3)) % (max_io_delay + 1);
			io_expect        = 1'b1;
			bus_xfer(addr, io_exp_req.wdata, io_exp_req.wstrb, rdata, cycles);
			io_expect = 1'b0;
			assert (rdata === io_exp_rdata)
				else value_error($sformatf("io read at %h gave %h, expected %h",
					addr, rdata, io_exp_rdata));
		end
	endtask

	task automatic divider_readback;
		logic [31:0] wdata;
		logic [3:0]  strb;
		logic [31:0] rdata;
		integer      cycles;
		bus_xfer(soc_map_pkg::UART_DIV_ADDR, 32'h0, 4'h0, rdata, cycles);
		assert (rdata === div_model)
			else value_error($sformatf("divider after reset %h, expected %h", rdata, div_model));
		for (int n = 0; n < div_rounds; n++) begin
			wdata = rand_bits(16);
			strb  = 4'(rand_bits(4));
			bus_xfer(soc_map_pkg::UART_DIV_ADDR, wdata, strb, rdata, cycles);
			div_model = merge_bytes(div_model, wdata, strb);
			bus_xfer(soc_map_pkg::UART_DIV_ADDR, 32'h0, 4'h0, rdata, cycles);
			assert (rdata === div_model)
				else value_error($sformatf("divider read %h, expected %h", rdata, div_model));
		end
	endtask

	task automatic uart_loopback;
		logic [31:0] wdata;
		logic [7:0]  tx_byte [2];
		logic [31:0] rdata;
		integer      cycles;
		bus_xfer(soc_map_pkg::UART_DIV_ADDR, 32'(uart_div), 4'hf, rdata, cycles);
		div_model = 32'(uart_div);
		bus_xfer(soc_map_pkg::UART_DAT_ADDR, 32'h0, 4'h0, rdata, cycles);
		assert (rdata === 32'hffff_ffff)
			else value_error($sformatf("empty receive buffer read %h", rdata));
		for (int n = 0; n < uart_bytes; n += 2) begin
			// the second write of a pair stalls while the first byte shifts out
			for (int k = 0; k < 2; k++) begin
				wdata      = rand_bits(32);
				tx_byte[k] = wdata[7:0];
				bus_xfer(soc_map_pkg::UART_DAT_ADDR, wdata, 4'b0001, rdata, cycles);
				assert ((k == 0) ? (cycles == 1) : (cycles > 1))
					else value_error($sformatf("data write %0d took %0d cycles",
						n + k, cycles));
			end
			for (int k = 0; k < 2; k++) begin
				rdata = 32'hffff_ffff;
				while (rdata === 32'hffff_ffff) begin
					bus_xfer(soc_map_pkg::UART_DAT_ADDR, 32'h0, 4'h0, rdata, cycles);
				end
				assert (rdata === {24'h0, tx_byte[k]})
					else value_error($sformatf("byte %0d received %h, sent %h",
						n + k, rdata, tx_byte[k]));
				bus_xfer(soc_map_pkg::UART_DAT_ADDR, 32'h0, 4'h0, rdata, cycles);
				assert (rdata === 32'hffff_ffff)
					else value_error($sformatf("buffer not emptied by read, got %h", rdata));
			end
		end
	endtask

	task automatic unmapped_access;
		logic [31:0] addr;
		logic [31:0] rdata;
		integer      cycles;
		for (int n = 0; n < unmapped_n; n++) begin
			// between the end of the sram and the uart page
			addr = rand_bits(25);
			if (addr < 32'(4 * mem_words)) begin
				addr = addr + 32'(4 * mem_words);
			end
			if (n == 0) begin
				addr = 32'(4 * mem_words);
			end else if (n == 1) begin
				addr = 32'h01ff_fffc;
			end
			bus_xfer(addr, rand_bits(32), 4'hf, rdata, cycles);
			assert (cycles == 1 && rdata === 32'h0)
				else value_error($sformatf("unmapped write at %h gave %h after %0d cycles",
					addr, rdata, cycles));
			bus_xfer(addr, 32'h0, 4'h0, rdata, cycles);
			assert (cycles == 1 && rdata === 32'h0)
				else value_error($sformatf("unmapped read at %h gave %h after %0d cycles",
					addr, rdata, cycles));
			// the sram word that the low address bits would select
			ram_check(int'(addr[31:2] % 32'(mem_words)));
		end
	endtask

	initial begin : main
		rst_n        = 1'b0;
		host_req     = '0;
		lfsr_q       = 16'd46462;
		io_expect    = 1'b0;
		io_exp_req   = '0;
		io_exp_rdata = '0;
		io_delay     = 0;
		div_model    = soc_map_pkg::UART_DIV_RESET;
		repeat (10) @(posedge clk);
		#drive_dly;
		rst_n = 1'b1;

		@(negedge clk);
		assert (ser_tx === 1'b1)
			else value_error($sformatf("ser_tx is %b after reset", ser_tx));
		assert (io_req.valid === 1'b0 && host_rsp.ready === 1'b0)
			else value_error($sformatf("io valid %b, host ready %b after reset",
				io_req.valid, host_rsp.ready));
		@(posedge clk);
		#drive_dly;

		sram_traffic();
		io_traffic();
		divider_readback();
		uart_loopback();
		unmapped_access();

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+tests
design/soc_bus_pkg.sv
design/soc_map_pkg.sv
design/soc_bus_decode.sv
design/soc_sram.sv
design/soc_uart.sv
design/soc_top.sv
tests/tb_soc.sv

/* run_sim.sh */
#!/bin/sh
# builds the soc testbench with verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f files.f --top-module tb_soc
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/Vtb_soc)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
echo "pass message not found in the simulation output"
exit 1
